// File: source/dram_bridge_pkg.sv
package dram_bridge_pkg;

   // bus widths
   localparam int WORD_W     = 32;
   localparam int BE_W       = 4;
   localparam int LANE_COUNT = 8;             // 32-bit lanes in the data part of a beat
   localparam int LANE_W     = 3;
   localparam int DATA_W     = 288;           // 256 data bits plus 32 ecc bits
   localparam int MASK_W     = DATA_W / 8;
   localparam int CMD_W      = 3;

   // opb bit 0 is the msb, so vectors run [N-1:0] with bit 0 at the lsb
   typedef logic [WORD_W-1:0] opb_word_t;
   typedef logic [BE_W-1:0]   opb_be_t;       // be[3] enables bits 31:24
   typedef logic [WORD_W-1:0] dram_addr_t;
   typedef logic [DATA_W-1:0] dram_data_t;
   typedef logic [MASK_W-1:0] dram_mask_t;    // 1 = byte not written
   typedef logic [LANE_W-1:0] lane_t;         // offset bits 4..2
   typedef logic [CMD_W-1:0]  dram_cmd_t;

   // user interface command codes
   localparam dram_cmd_t CMD_WRITE = 3'd0;
   localparam dram_cmd_t CMD_READ  = 3'd1;

   // inclusive opb address window
   localparam opb_word_t BASE_ADDR = 32'h8000_0000;
   localparam opb_word_t HIGH_ADDR = 32'h8FFF_FFFF;

endpackage

// File: source/bridge_xfer_if.sv
interface bridge_xfer_if;
   import dram_bridge_pkg::*;

   // request side driven by the controller
   dram_addr_t addr;                          // burst-aligned offset
   lane_t      lane;
   opb_word_t  wdata;
   opb_be_t    be;
   logic       cmd_start;
   logic       cmd_rnw;
   logic       wdf_start;
   logic       rd_start;

   // completion pulses and read data
   logic       cmd_done;
   logic       wdf_done;
   logic       rd_done;
   opb_word_t  rdata;

   modport ctrl (
      output addr, lane, wdata, be, cmd_start, cmd_rnw, wdf_start, rd_start,
      input  cmd_done, wdf_done, rd_done, rdata
   );

   modport cmd (input addr, cmd_start, cmd_rnw, output cmd_done);

   modport wdf (input lane, wdata, be, wdf_start, output wdf_done);

   modport rd (input lane, rd_start, output rd_done, rdata);

endinterface

// File: source/opb_slave_ctrl.sv
module opb_slave_ctrl (
   input  logic                       OPB_Clk,
   input  logic                       dram_rst,
   input  logic                       opb_select,
   input  logic                       opb_rnw,
   input  dram_bridge_pkg::opb_word_t opb_abus,
   input  dram_bridge_pkg::opb_word_t opb_dbus,
   input  dram_bridge_pkg::opb_be_t   opb_be,
   output dram_bridge_pkg::opb_word_t sl_dbus,
   output logic                       sl_xfer_ack,
   output logic                       sl_err_ack,
   output logic                       sl_tout_sup,
   bridge_xfer_if.ctrl                xfer
);
   import dram_bridge_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_WR_DATA,
      S_WR_CMD,
      S_RD_CMD,
      S_RD_DATA,
      S_ACK
   } state_t;

   state_t    state;
   opb_word_t offset;
   logic      in_window;
   logic      accept;

   assign in_window = (opb_abus >= BASE_ADDR) && (opb_abus <= HIGH_ADDR);
   assign offset    = opb_abus - BASE_ADDR;

   // select is still high during the errAck cycle, so don't take it twice
   assign accept = (state == S_IDLE) && opb_select && !sl_err_ack;

   always_ff @(posedge OPB_Clk) begin
      if (dram_rst) begin
         state          <= S_IDLE;
         sl_err_ack     <= 1'b0;
         sl_dbus        <= '0;
         xfer.cmd_start <= 1'b0;
         xfer.wdf_start <= 1'b0;
         xfer.rd_start  <= 1'b0;
      end else begin
         sl_err_ack     <= 1'b0;
         sl_dbus        <= '0;                // bus is zero outside the read ack
         xfer.cmd_start <= 1'b0;
         xfer.wdf_start <= 1'b0;
         xfer.rd_start  <= 1'b0;

         case (state)
            S_IDLE: begin
               if (accept) begin
                  if (!in_window) begin
                     sl_err_ack <= 1'b1;      // one cycle after select
                  end else if (opb_rnw) begin
                     state          <= S_RD_CMD;
                     xfer.cmd_start <= 1'b1;
                  end else begin
                     state          <= S_WR_DATA;
                     xfer.wdf_start <= 1'b1;  // data beats go ahead of the command
                  end
               end
            end
            S_WR_DATA: begin
               if (xfer.wdf_done) begin
                  state          <= S_WR_CMD;
                  xfer.cmd_start <= 1'b1;
               end
            end
            S_WR_CMD: begin
               if (xfer.cmd_done) begin
                  state <= S_ACK;
               end
            end
            S_RD_CMD: begin
               if (xfer.cmd_done) begin
                  state         <= S_RD_DATA;
                  xfer.rd_start <= 1'b1;
               end
            end
            S_RD_DATA: begin
               if (xfer.rd_done) begin
                  state   <= S_ACK;
                  sl_dbus <= xfer.rdata;      // valid in the ack cycle only
               end
            end
            S_ACK: begin
               state <= S_IDLE;
            end
            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   // request payload held for the whole transaction
   always_ff @(posedge OPB_Clk) begin
      if (accept && in_window) begin
         xfer.addr    <= {offset[31:5], 5'b0};
         xfer.lane    <= offset[4:2];
         xfer.wdata   <= opb_dbus;
         xfer.be      <= opb_be;
         xfer.cmd_rnw <= opb_rnw;
      end
   end

   assign sl_xfer_ack = (state == S_ACK);
   assign sl_tout_sup = (state != S_IDLE);    // from accept through the ack

endmodule

// File: source/dram_cmd_issue.sv
module dram_cmd_issue (
   input  logic                        OPB_Clk,
   input  logic                        dram_rst,
   bridge_xfer_if.cmd                  xfer,
   input  logic                        dram_rdy,
   output dram_bridge_pkg::dram_addr_t dram_addr,
   output dram_bridge_pkg::dram_cmd_t  dram_cmd,
   output logic                        dram_en
);
   import dram_bridge_pkg::*;

   logic take;
   logic taken;

   assign take  = xfer.cmd_start && !dram_en;
   assign taken = dram_en && dram_rdy;        // controller accepts this cycle

   always_ff @(posedge OPB_Clk) begin
      if (dram_rst) begin
         dram_en       <= 1'b0;
         xfer.cmd_done <= 1'b0;
      end else begin
         xfer.cmd_done <= 1'b0;
         if (take) begin
            dram_en <= 1'b1;
         end else if (taken) begin
            dram_en       <= 1'b0;
            xfer.cmd_done <= 1'b1;
         end
      end
   end

   // address and command hold with dram_en, then drop back to zero
   always_ff @(posedge OPB_Clk) begin
      if (take) begin
         dram_addr <= xfer.addr;
         dram_cmd  <= xfer.cmd_rnw ? CMD_READ : CMD_WRITE;
      end else if (taken) begin
         dram_addr <= '0;
         dram_cmd  <= CMD_WRITE;
      end
   end

endmodule

// File: source/dram_wdf_writer.sv
module dram_wdf_writer (
   input  logic                        OPB_Clk,
   input  logic                        dram_rst,
   bridge_xfer_if.wdf                  xfer,
   input  logic                        dram_wdf_rdy,
   output dram_bridge_pkg::dram_data_t dram_wdf_data,
   output dram_bridge_pkg::dram_mask_t dram_wdf_mask,
   output logic                        dram_wdf_wren,
   output logic                        dram_wdf_end
);
   import dram_bridge_pkg::*;

   typedef enum logic [1:0] {
      W_IDLE,
      W_BEAT0,
      W_BEAT1
   } wstate_t;

   wstate_t    state;
   dram_data_t lane_data;
   dram_mask_t lane_mask;

   // word placed in its lane, all other bytes masked (ecc bytes included)
   always_comb begin
      lane_data = '0;
      lane_mask = '1;
      for (int i = 0; i < LANE_COUNT; i++) begin
         if (xfer.lane == lane_t'(i)) begin
            lane_data[i*WORD_W +: WORD_W] = xfer.wdata;
            lane_mask[i*BE_W +: BE_W]     = ~xfer.be;
         end
      end
   end

   always_ff @(posedge OPB_Clk) begin
      if (dram_rst) begin
         state         <= W_IDLE;
         xfer.wdf_done <= 1'b0;
      end else begin
         xfer.wdf_done <= 1'b0;
         case (state)
            W_IDLE:  if (xfer.wdf_start) state <= W_BEAT0;
            W_BEAT0: if (dram_wdf_rdy) state <= W_BEAT1;
            W_BEAT1: begin
               if (dram_wdf_rdy) begin
                  state         <= W_IDLE;
                  xfer.wdf_done <= 1'b1;     // both beats are in the fifo
               end
            end
            default: state <= W_IDLE;
         endcase
      end
   end

   always_ff @(posedge OPB_Clk) begin
      if (state == W_IDLE && xfer.wdf_start) begin
         dram_wdf_data <= lane_data;
         dram_wdf_mask <= lane_mask;
      end else if (state == W_BEAT0 && dram_wdf_rdy) begin
         dram_wdf_data <= '0;
         dram_wdf_mask <= '1;                 // second beat writes nothing
      end
   end

   assign dram_wdf_wren = (state != W_IDLE);
   assign dram_wdf_end  = (state == W_BEAT1);

endmodule

// File: source/dram_rd_capture.sv
module dram_rd_capture (
   input  logic                        OPB_Clk,
   input  logic                        dram_rst,
   bridge_xfer_if.rd                   xfer,
   input  dram_bridge_pkg::dram_data_t dram_rd_data,
   input  logic                        dram_rd_data_valid,
   input  logic                        dram_rd_data_end
);
   import dram_bridge_pkg::*;

   typedef enum logic {
      R_IDLE,
      R_WAIT
   } rstate_t;

   rstate_t state;
   logic    captured;                         // first valid beat already taken
   logic    grab;

   assign grab = (state == R_WAIT) && dram_rd_data_valid && !captured;

   always_ff @(posedge OPB_Clk) begin
      if (dram_rst) begin
         state        <= R_IDLE;
         captured     <= 1'b0;
         xfer.rd_done <= 1'b0;
      end else begin
         xfer.rd_done <= 1'b0;
         case (state)
            R_IDLE: begin
               if (xfer.rd_start) begin
                  state    <= R_WAIT;
                  captured <= 1'b0;
               end
            end
            R_WAIT: begin
               if (grab) begin
                  captured <= 1'b1;
               end
               if (dram_rd_data_end) begin
                  state        <= R_IDLE;
                  xfer.rd_done <= 1'b1;       // one cycle after the end beat
               end
            end
            default: state <= R_IDLE;
         endcase
      end
   end

   always_ff @(posedge OPB_Clk) begin
      if (grab) begin
         xfer.rdata <= dram_rd_data[WORD_W*xfer.lane +: WORD_W];
      end
   end

endmodule

// File: source/opb_dram_bridge.sv
module opb_dram_bridge (
   input  logic                        OPB_Clk,
   input  logic                        dram_rst,
   // opb slave
   input  logic                        OPB_select,
   input  logic                        OPB_RNW,
   input  dram_bridge_pkg::opb_word_t  OPB_ABus,
   input  dram_bridge_pkg::opb_word_t  OPB_DBus,
   input  dram_bridge_pkg::opb_be_t    OPB_BE,
   output dram_bridge_pkg::opb_word_t  Sl_DBus,
   output logic                        Sl_xferAck,
   output logic                        Sl_errAck,
   output logic                        Sl_toutSup,
   // ddr3 user interface
   input  logic                        dram_rdy,
   input  logic                        dram_wdf_rdy,
   input  dram_bridge_pkg::dram_data_t dram_rd_data,
   input  logic                        dram_rd_data_valid,
   input  logic                        dram_rd_data_end,
   output dram_bridge_pkg::dram_addr_t dram_addr,
   output dram_bridge_pkg::dram_cmd_t  dram_cmd,
   output logic                        dram_en,
   output dram_bridge_pkg::dram_data_t dram_wdf_data,
   output dram_bridge_pkg::dram_mask_t dram_wdf_mask,
   output logic                        dram_wdf_wren,
   output logic                        dram_wdf_end
);

   bridge_xfer_if xfer ();

   opb_slave_ctrl u_ctrl (
      .OPB_Clk     (OPB_Clk),
      .dram_rst    (dram_rst),
      .opb_select  (OPB_select),
      .opb_rnw     (OPB_RNW),
      .opb_abus    (OPB_ABus),
      .opb_dbus    (OPB_DBus),
      .opb_be      (OPB_BE),
      .sl_dbus     (Sl_DBus),
      .sl_xfer_ack (Sl_xferAck),
      .sl_err_ack  (Sl_errAck),
      .sl_tout_sup (Sl_toutSup),
      .xfer        (xfer.ctrl)
   );

   dram_cmd_issue u_cmd (
      .OPB_Clk   (OPB_Clk),
      .dram_rst  (dram_rst),
      .xfer      (xfer.cmd),
      .dram_rdy  (dram_rdy),
      .dram_addr (dram_addr),
      .dram_cmd  (dram_cmd),
      .dram_en   (dram_en)
   );

   dram_wdf_writer u_wdf (
      .OPB_Clk       (OPB_Clk),
      .dram_rst      (dram_rst),
      .xfer          (xfer.wdf),
      .dram_wdf_rdy  (dram_wdf_rdy),
      .dram_wdf_data (dram_wdf_data),
      .dram_wdf_mask (dram_wdf_mask),
      .dram_wdf_wren (dram_wdf_wren),
      .dram_wdf_end  (dram_wdf_end)
   );

   dram_rd_capture u_rd (
      .OPB_Clk            (OPB_Clk),
      .dram_rst           (dram_rst),
      .xfer               (xfer.rd),
      .dram_rd_data       (dram_rd_data),
      .dram_rd_data_valid (dram_rd_data_valid),
      .dram_rd_data_end   (dram_rd_data_end)
   );

endmodule

// File: tb/dram_ui_model.sv
module dram_ui_model (
   input  logic                        OPB_Clk,
   input  logic                        dram_rst,
   input  dram_bridge_pkg::dram_addr_t dram_addr,
   input  dram_bridge_pkg::dram_cmd_t  dram_cmd,
   input  logic                        dram_en,
   input  dram_bridge_pkg::dram_data_t dram_wdf_data,
   input  dram_bridge_pkg::dram_mask_t dram_wdf_mask,
   input  logic                        dram_wdf_wren,
   input  logic                        dram_wdf_end,
   output logic                        dram_rdy,
   output logic                        dram_wdf_rdy,
   output dram_bridge_pkg::dram_data_t dram_rd_data,
   output logic                        dram_rd_data_valid,
   output logic                        dram_rd_data_end
);
   timeunit 1ns;
   timeprecision 100ps;
   import dram_bridge_pkg::*;

   logic [255:0] mem [dram_addr_t];           // data part of each burst
   dram_addr_t   rd_q[$];                     // accepted reads not yet returned
   logic [255:0] wr_data;                     // beat 0 waiting for its command
   logic [31:0]  wr_mask;
   logic [31:0]  lcg;
   int           rd_phase;
   int           rd_delay;

   function automatic logic [31:0] next_rand();
      lcg = lcg * 32'd1664525 + 32'd1013904223;
      return lcg >> 16;
   endfunction

   // unwritten bursts read back a pattern built from the whole address
   function automatic logic [255:0] stored(dram_addr_t a);
      logic [255:0] d;
      if (mem.exists(a)) return mem[a];
      for (int i = 0; i < LANE_COUNT; i++) begin
         d[i*32 +: 32] = a ^ (32'h9E37_79B9 * (i + 1));
      end
      return d;
   endfunction

   initial begin
      lcg                = 32'd916;
      dram_rdy           = 1'b0;
      dram_wdf_rdy       = 1'b0;
      dram_rd_data       = '0;
      dram_rd_data_valid = 1'b0;
      dram_rd_data_end   = 1'b0;
      wr_data            = '0;
      wr_mask            = '1;
      rd_phase           = 0;
      rd_delay           = 0;
   end

   always @(posedge OPB_Clk) begin
      if (dram_rst) begin
         rd_q.delete();
      end else begin
         if (dram_wdf_wren && dram_wdf_rdy && !dram_wdf_end) begin
            wr_data = dram_wdf_data[255:0];
            wr_mask = dram_wdf_mask[31:0];    // ecc bytes are not stored
         end
         if (dram_en && dram_rdy && dram_cmd == CMD_WRITE) begin
            mem[dram_addr] = stored(dram_addr);
            for (int b = 0; b < 32; b++) begin
               if (!wr_mask[b]) mem[dram_addr][b*8 +: 8] = wr_data[b*8 +: 8];
            end
         end else if (dram_en && dram_rdy) begin
            rd_q.push_back(dram_addr);
         end
      end
   end

   always @(negedge OPB_Clk) begin
      dram_rdy           <= (next_rand() % 4) != 0;
      dram_wdf_rdy       <= (next_rand() % 3) != 0;
      dram_rd_data_valid <= 1'b0;
      dram_rd_data_end   <= 1'b0;
      if (dram_rst) begin
         rd_phase = 0;
      end else if (rd_phase == 0 && rd_q.size() != 0) begin
         rd_delay = 1 + next_rand() % 4;      // capture block is armed by then
         rd_phase = 1;
      end else if (rd_phase == 1 && rd_delay > 0) begin
         rd_delay--;
      end else if (rd_phase == 1) begin
         dram_rd_data       <= {32'h0, stored(rd_q[0])};
         dram_rd_data_valid <= 1'b1;
         rd_phase = 2;
      end else if (rd_phase == 2 && next_rand() % 2 == 0) begin
         dram_rd_data       <= {32'h0, ~stored(rd_q[0])};  // must be ignored
         dram_rd_data_valid <= 1'b1;
         dram_rd_data_end   <= 1'b1;
         void'(rd_q.pop_front());
         rd_phase = 0;
      end
   end

endmodule

// File: tb/tb_opb_dram_bridge.sv
module tb_opb_dram_bridge;
   timeunit 1ns;
   timeprecision 100ps;
   import dram_bridge_pkg::*;

   typedef struct {
      string     name;
      logic      rnw;
      opb_word_t addr;
      opb_word_t data;
      opb_be_t   be;
      logic      expect_err;
   } entry_t;

   localparam int NUM_TESTS   = 15;
   localparam int WATCHDOG_NS = NUM_TESTS * 200 * 40;

   logic       OPB_Clk = 1'b0;
   logic       dram_rst, OPB_select, OPB_RNW, Sl_xferAck, Sl_errAck, Sl_toutSup;
   opb_word_t  OPB_ABus, OPB_DBus, Sl_DBus;
   opb_be_t    OPB_BE;
   logic       dram_rdy, dram_wdf_rdy, dram_rd_data_valid, dram_rd_data_end;
   logic       dram_en, dram_wdf_wren, dram_wdf_end;
   dram_data_t dram_rd_data, dram_wdf_data;
   dram_mask_t dram_wdf_mask;
   dram_addr_t dram_addr;
   dram_cmd_t  dram_cmd;

   entry_t     tests [NUM_TESTS];
   opb_word_t  shadow [opb_word_t];           // expected memory, by word address
   string      cur_name;
   dram_addr_t exp_addr;
   dram_cmd_t  exp_cmd;
   dram_mask_t exp_mask;                      // beat 0 mask of the current write
   int         cmd_count;
   int         beat_count;

   opb_dram_bridge uut (.*);
   dram_ui_model model (.*);

   always #20 OPB_Clk = ~OPB_Clk;

   task automatic abort_run(string what);
      $display("%s", what);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_word(string name, opb_word_t exp, opb_word_t act);
      if (act !== exp) begin
         abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_addr(string name, dram_addr_t exp, dram_addr_t act);
      if (act !== exp) begin
         abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_cmd(string name, dram_cmd_t exp, dram_cmd_t act);
      if (act !== exp) begin
         abort_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
      end
   endtask

   task automatic check_mask(string name, dram_mask_t exp, dram_mask_t act);
      if (act !== exp) begin
         abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_flag(string name, logic exp, logic act);
      if (act !== exp) begin
         abort_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   // be[3] enables the most significant byte
   function automatic opb_word_t merge_bytes(opb_word_t old, opb_word_t data, opb_be_t be);
      opb_word_t r;
      r = old;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) r[b*8 +: 8] = data[b*8 +: 8];
      end
      return r;
   endfunction

   always @(posedge OPB_Clk) begin
      if (!dram_rst && dram_en && dram_rdy) begin   // command taken on this edge
         check_cmd({cur_name, " dram_cmd"}, exp_cmd, dram_cmd);
         check_addr({cur_name, " dram_addr"}, exp_addr, dram_addr);
         cmd_count++;
      end
   end

   // even beats carry the word, odd beats are the fully masked end beat
   always @(posedge OPB_Clk) begin
      if (!dram_rst && dram_wdf_wren && dram_wdf_rdy) begin
         if (beat_count % 2 == 0) begin
            check_flag({cur_name, " beat0 end"}, 1'b0, dram_wdf_end);
            check_mask({cur_name, " beat0 mask"}, exp_mask, dram_wdf_mask);
         end else begin
            check_flag({cur_name, " beat1 end"}, 1'b1, dram_wdf_end);
            check_mask({cur_name, " beat1 mask"}, '1, dram_wdf_mask);
         end
         beat_count++;
      end
   end

   task automatic run_entry(entry_t t);
      opb_word_t wa;
      int        cmds;
      int        beats;
      int        lane;
      wa       = {t.addr[31:2], 2'b00};
      cur_name = t.name;
      exp_cmd  = t.rnw ? CMD_READ : CMD_WRITE;
      exp_addr = (t.addr - BASE_ADDR) & ~32'h1F;
      lane     = ((t.addr - BASE_ADDR) >> 2) & 7;
      exp_mask = '1;
      for (int b = 0; b < 4; b++) begin
         if (t.be[b]) exp_mask[lane*4 + b] = 1'b0;
      end
      cmds     = cmd_count;
      beats    = beat_count;
      check_flag({t.name, " idle toutSup"}, 1'b0, Sl_toutSup);
      OPB_select = 1'b1;
      OPB_RNW    = t.rnw;
      OPB_ABus   = t.addr;
      OPB_DBus   = t.rnw ? 32'h0 : t.data;
      OPB_BE     = t.be;
      @(negedge OPB_Clk);
      if (t.expect_err) begin
         check_flag({t.name, " errAck"}, 1'b1, Sl_errAck);
         check_flag({t.name, " xferAck"}, 1'b0, Sl_xferAck);
         check_flag({t.name, " dram_en"}, 1'b0, dram_en);
      end else begin
         while (!Sl_xferAck) begin           // watchdog bounds this wait
            check_flag({t.name, " toutSup"}, 1'b1, Sl_toutSup);
            check_flag({t.name, " errAck"}, 1'b0, Sl_errAck);
            check_word({t.name, " Sl_DBus before ack"}, 32'h0, Sl_DBus);
            @(negedge OPB_Clk);
         end
         check_flag({t.name, " toutSup at ack"}, 1'b1, Sl_toutSup);
         if (t.rnw) begin
            check_word({t.name, " read data"}, shadow[wa], Sl_DBus);
         end else begin
            check_word({t.name, " Sl_DBus on write"}, 32'h0, Sl_DBus);
            shadow[wa] = merge_bytes(shadow.exists(wa) ? shadow[wa] : 32'h0, t.data, t.be);
         end
      end
      OPB_select = 1'b0;
      OPB_ABus   = 32'h0;
      OPB_DBus   = 32'h0;
      OPB_BE     = 4'h0;
      @(negedge OPB_Clk);
      check_flag({t.name, " xferAck after ack"}, 1'b0, Sl_xferAck);
      check_flag({t.name, " errAck after ack"}, 1'b0, Sl_errAck);
      if (cmd_count != cmds + (t.expect_err ? 0 : 1)) begin
         abort_run($sformatf("%s issued %0d DRAM commands instead of the expected count",
                             t.name, cmd_count - cmds));
      end
      if (beat_count != beats + ((t.rnw || t.expect_err) ? 0 : 2)) begin
         abort_run($sformatf("%s sent %0d write FIFO beats instead of the expected count",
                             t.name, beat_count - beats));
      end
   endtask

   initial begin
      tests = '{
         '{"wr_lane0",     1'b0, 32'h8000_0000, 32'hDEAD_BEEF, 4'hF, 1'b0},
         '{"wr_lane3",     1'b0, 32'h8000_000C, 32'h0BAD_F00D, 4'hF, 1'b0},
         '{"rd_lane0",     1'b1, 32'h8000_0000, 32'h0,         4'hF, 1'b0},
         '{"rd_lane3",     1'b1, 32'h8000_000C, 32'h0,         4'hF, 1'b0},
         '{"wr_lane7_far", 1'b0, 32'h8123_45FC, 32'hCAFE_F00D, 4'hF, 1'b0},
         '{"part_lane3",   1'b0, 32'h8000_000C, 32'h55AA_55AA, 4'hA, 1'b0},
         '{"rd_lane3_part",1'b1, 32'h8000_000C, 32'h0,         4'hF, 1'b0},
         '{"rd_lane0_keep",1'b1, 32'h8000_0000, 32'h0,         4'hF, 1'b0},
         '{"rd_lane7_far", 1'b1, 32'h8123_45FC, 32'h0,         4'hF, 1'b0},
         '{"err_below",    1'b1, 32'h7FFF_FFFC, 32'h0,         4'hF, 1'b1},
         '{"err_above",    1'b0, 32'h9000_0000, 32'h1234_5678, 4'hF, 1'b1},
         '{"part_lane7",   1'b0, 32'h8123_45FC, 32'h1234_5678, 4'h1, 1'b0},
         '{"rd_lane7_part",1'b1, 32'h8123_45FC, 32'h0,         4'hF, 1'b0},
         '{"wr_top_lane1", 1'b0, 32'h8FFF_FFE4, 32'hA5A5_5A5A, 4'hF, 1'b0},
         '{"rd_top_lane1", 1'b1, 32'h8FFF_FFE4, 32'h0,         4'hF, 1'b0}
      };
      dram_rst   = 1'b1;
      OPB_select = 1'b0;
      OPB_RNW    = 1'b0;
      OPB_ABus   = 32'h0;
      OPB_DBus   = 32'h0;
      OPB_BE     = 4'h0;
      cmd_count  = 0;
      beat_count = 0;
      exp_mask   = '1;
      cur_name   = "reset";
      repeat (4) @(posedge OPB_Clk);
      @(negedge OPB_Clk);
      dram_rst = 1'b0;
      repeat (6) begin                        // quiet bus after reset
         @(negedge OPB_Clk);
         check_flag("reset Sl_xferAck", 1'b0, Sl_xferAck);
         check_flag("reset Sl_errAck", 1'b0, Sl_errAck);
         check_flag("reset Sl_toutSup", 1'b0, Sl_toutSup);
         check_flag("reset dram_en", 1'b0, dram_en);
         check_flag("reset dram_wdf_wren", 1'b0, dram_wdf_wren);
      end
      foreach (tests[i]) run_entry(tests[i]);
      $display(">>> PASS");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      abort_run("timeout: the table did not finish before the watchdog expired");
   end

endmodule

// File: filelist.f
source/dram_bridge_pkg.sv
source/bridge_xfer_if.sv
source/opb_slave_ctrl.sv
source/dram_cmd_issue.sv
source/dram_wdf_writer.sv
source/dram_rd_capture.sv
source/opb_dram_bridge.sv
tb/dram_ui_model.sv
tb/tb_opb_dram_bridge.sv

// File: Bender.yml
package:
  name: opb_dram_bridge

sources:
  - source/dram_bridge_pkg.sv
  - source/bridge_xfer_if.sv
  - source/opb_slave_ctrl.sv
  - source/dram_cmd_issue.sv
  - source/dram_wdf_writer.sv
  - source/dram_rd_capture.sv
  - source/opb_dram_bridge.sv
  - target: test
    files:
      - tb/dram_ui_model.sv
      - tb/tb_opb_dram_bridge.sv
